// File: design/rvDecodePkg.sv
`default_nettype none

package rvDecodePkg;

    localparam int Xlen = 64;

    typedef logic [Xlen-1:0] xlenT;  // register or result value
    typedef logic [31:0]     instrT; // one instruction word
    typedef logic [4:0]      regIdxT;

    // major opcodes of RV64IM
    localparam logic [6:0] OpLoad   = 7'b0000011;
    localparam logic [6:0] OpImm    = 7'b0010011;
    localparam logic [6:0] OpAuipc  = 7'b0010111;
    localparam logic [6:0] OpImm32  = 7'b0011011;
    localparam logic [6:0] OpStore  = 7'b0100011;
    localparam logic [6:0] OpReg    = 7'b0110011;
    localparam logic [6:0] OpLui    = 7'b0110111;
    localparam logic [6:0] OpReg32  = 7'b0111011;
    localparam logic [6:0] OpBranch = 7'b1100011;
    localparam logic [6:0] OpJalr   = 7'b1100111;
    localparam logic [6:0] OpJal    = 7'b1101111;

    // ALU operation codes, values shared with the execute stage
    typedef enum logic [5:0] {
        aluNop  = 6'd0,  aluSll  = 6'd1,  aluSrl  = 6'd2,  aluSra  = 6'd3,
        aluAdd  = 6'd4,  aluSub  = 6'd5,  aluDiv  = 6'd6,  aluDivu = 6'd7,
        aluRem  = 6'd8,  aluRemu = 6'd9,  aluMul  = 6'd10, aluMulh = 6'd11,
        aluMulhu = 6'd12, aluMulhsu = 6'd13,
        aluXor  = 6'd14, aluOr   = 6'd15, aluAnd  = 6'd16,
        aluSlt  = 6'd17, aluSltu = 6'd18,
        aluAuipc = 6'd19, aluLui = 6'd20, aluJalr = 6'd21, aluJal = 6'd22,
        aluBeq  = 6'd23, aluBne  = 6'd24, aluBlt  = 6'd25, aluBge  = 6'd26,
        aluBltu = 6'd27, aluBgeu = 6'd28,
        aluSllw = 6'd33, aluSrlw = 6'd34, aluSraw = 6'd35, aluAddw = 6'd36,
        aluSubw = 6'd37, aluDivw = 6'd38, aluDivuw = 6'd39, aluRemw = 6'd40,
        aluRemuw = 6'd41, aluMulw = 6'd42
    } aluOpT;

    typedef enum logic [1:0] {
        resAlu     = 2'd0,
        resMem     = 2'd1,
        resPcPlus4 = 2'd2  // link value of jal and jalr
    } resultSrcT;

    typedef enum logic [1:0] {
        memNone  = 2'd0,
        memLoad  = 2'd1,
        memStore = 2'd2
    } memOpT;

    typedef struct packed {
        memOpT      op;
        logic [2:0] size; // funct3 of the load or store
    } memAccessT;

    typedef struct packed {
        logic      regWrite;
        resultSrcT resultSrc;
        memAccessT mem;
        logic      aluSrc;   // immediate as second ALU operand
        aluOpT     aluOp;
        xlenT      imm;
        regIdxT    rs1;
        regIdxT    rs2;
        regIdxT    rd;
        logic      branch;
        logic      jump;
    } ctrlT;

    typedef struct packed {
        ctrlT ctrl;
        xlenT rd1;
        xlenT rd2;
    } laneT;

    typedef struct packed {
        logic   regWrite;
        regIdxT rd;
        xlenT   result;
    } wbT;

endpackage

`default_nettype wire

// File: design/instrDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module instrDecoder
    import rvDecodePkg::*;
(
    input  instrT instr,
    output ctrlT  ctrl
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    regIdxT     rs1F;
    regIdxT     rs2F;
    regIdxT     rdF;
    xlenT       immI;
    xlenT       immS;
    xlenT       immB;
    xlenT       immU;
    xlenT       immJ;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign rs1F   = instr[19:15];
    assign rs2F   = instr[24:20];
    assign rdF    = instr[11:7];

    // immediates, all sign extended from instr[31]
    assign immI = {{52{instr[31]}}, instr[31:20]};
    assign immS = {{52{instr[31]}}, instr[31:25], instr[11:7]};
    assign immB = {{52{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign immU = {{32{instr[31]}}, instr[31:12], 12'b0};
    assign immJ = {{44{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        ctrl = '0; // unknown opcodes leave the word all zero
        case (opcode)
            OpLoad: begin
                ctrl.regWrite  = 1'b1;
                ctrl.resultSrc = resMem;
                ctrl.mem.op    = memLoad;
                ctrl.mem.size  = funct3;
                ctrl.aluSrc    = 1'b1;
                ctrl.imm       = immI;
                ctrl.rs1       = rs1F;
                ctrl.rd        = rdF;
                ctrl.aluOp     = aluAdd; // address calculation
            end
            OpImm: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.imm      = immI;
                ctrl.rs1      = rs1F;
                ctrl.rd       = rdF;
                case (funct3)
                    3'b000: ctrl.aluOp = aluAdd;
                    3'b001: if (instr[31:26] == 6'b000000) ctrl.aluOp = aluSll;
                    3'b010: ctrl.aluOp = aluSlt;
                    3'b011: ctrl.aluOp = aluSltu;
                    3'b100: ctrl.aluOp = aluXor;
                    3'b101: begin
                        // 6-bit shamt, so funct7 bit 25 belongs to the amount
                        if (instr[31:26] == 6'b000000) ctrl.aluOp = aluSrl;
                        else if (instr[31:26] == 6'b010000) ctrl.aluOp = aluSra;
                    end
                    3'b110: ctrl.aluOp = aluOr;
                    default: ctrl.aluOp = aluAnd;
                endcase
            end
            OpAuipc, OpLui: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.imm      = immU;
                ctrl.rd       = rdF;
                ctrl.aluOp    = (opcode == OpLui) ? aluLui : aluAuipc;
            end
            OpImm32: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.imm      = immI;
                ctrl.rs1      = rs1F;
                ctrl.rd       = rdF;
                case (funct3)
                    3'b000: ctrl.aluOp = aluAddw; // addiw
                    3'b001: if (funct7 == 7'b0000000) ctrl.aluOp = aluSllw;
                    3'b101: begin
                        if (funct7 == 7'b0000000) ctrl.aluOp = aluSrlw;
                        else if (funct7 == 7'b0100000) ctrl.aluOp = aluSraw;
                    end
                    default: ctrl.aluOp = aluNop;
                endcase
            end
            OpStore: begin
                ctrl.mem.op   = memStore;
                ctrl.mem.size = funct3;
                ctrl.aluSrc   = 1'b1;
                ctrl.imm      = immS;
                ctrl.rs1      = rs1F;
                ctrl.rs2      = rs2F;
                ctrl.rd       = rdF; // low immediate bits, regWrite stays low
                ctrl.aluOp    = aluAdd;
            end
            OpReg: begin
                ctrl.regWrite = 1'b1;
                ctrl.rs1      = rs1F;
                ctrl.rs2      = rs2F;
                ctrl.rd       = rdF;
                if (funct7 == 7'b0000001) begin // M extension
                    case (funct3)
                        3'b000: ctrl.aluOp = aluMul;
                        3'b001: ctrl.aluOp = aluMulh;
                        3'b010: ctrl.aluOp = aluMulhsu;
                        3'b011: ctrl.aluOp = aluMulhu;
                        3'b100: ctrl.aluOp = aluDiv;
                        3'b101: ctrl.aluOp = aluDivu;
                        3'b110: ctrl.aluOp = aluRem;
                        default: ctrl.aluOp = aluRemu;
                    endcase
                end else if (funct7 == 7'b0000000) begin
                    case (funct3)
                        3'b000: ctrl.aluOp = aluAdd;
                        3'b001: ctrl.aluOp = aluSll;
                        3'b010: ctrl.aluOp = aluSlt;
                        3'b011: ctrl.aluOp = aluSltu;
                        3'b100: ctrl.aluOp = aluXor;
                        3'b101: ctrl.aluOp = aluSrl;
                        3'b110: ctrl.aluOp = aluOr;
                        default: ctrl.aluOp = aluAnd;
                    endcase
                end else if (funct7 == 7'b0100000) begin
                    if (funct3 == 3'b000) ctrl.aluOp = aluSub;
                    else if (funct3 == 3'b101) ctrl.aluOp = aluSra;
                end
            end
            OpReg32: begin
                ctrl.regWrite = 1'b1;
                ctrl.rs1      = rs1F;
                ctrl.rs2      = rs2F;
                ctrl.rd       = rdF;
                if (funct7 == 7'b0000001) begin
                    case (funct3)
                        3'b000: ctrl.aluOp = aluMulw;
                        3'b100: ctrl.aluOp = aluDivw;
                        3'b101: ctrl.aluOp = aluDivuw;
                        3'b110: ctrl.aluOp = aluRemw;
                        3'b111: ctrl.aluOp = aluRemuw;
                        default: ctrl.aluOp = aluNop;
                    endcase
                end else if (funct7 == 7'b0000000) begin
                    case (funct3)
                        3'b000: ctrl.aluOp = aluAddw;
                        3'b001: ctrl.aluOp = aluSllw;
                        3'b101: ctrl.aluOp = aluSrlw;
                        default: ctrl.aluOp = aluNop;
                    endcase
                end else if (funct7 == 7'b0100000) begin
                    if (funct3 == 3'b000) ctrl.aluOp = aluSubw;
                    else if (funct3 == 3'b101) ctrl.aluOp = aluSraw;
                end
            end
            OpBranch: begin
                ctrl.branch = 1'b1;
                ctrl.imm    = immB;
                ctrl.rs1    = rs1F;
                ctrl.rs2    = rs2F;
                case (funct3)
                    3'b000: ctrl.aluOp = aluBeq;
                    3'b001: ctrl.aluOp = aluBne;
                    3'b100: ctrl.aluOp = aluBlt;
                    3'b101: ctrl.aluOp = aluBge;
                    3'b110: ctrl.aluOp = aluBltu;
                    3'b111: ctrl.aluOp = aluBgeu;
                    default: ctrl.aluOp = aluNop;
                endcase
            end
            OpJalr: begin
                ctrl.regWrite  = 1'b1;
                ctrl.resultSrc = resPcPlus4;
                ctrl.jump      = 1'b1;
                ctrl.aluSrc    = 1'b1;
                ctrl.imm       = immI;
                ctrl.rs1       = rs1F;
                ctrl.rd        = rdF;
                ctrl.aluOp     = aluJalr;
            end
            OpJal: begin
                ctrl.regWrite  = 1'b1;
                ctrl.resultSrc = resPcPlus4;
                ctrl.jump      = 1'b1;
                ctrl.aluSrc    = 1'b1;
                ctrl.imm       = immJ;
                ctrl.rd        = rdF;
                ctrl.aluOp     = aluJal;
            end
            default: ctrl = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: design/regFile.sv
`timescale 1ns/1ps
`default_nettype none

module regFile
    import rvDecodePkg::*;
(
    input  wire logic   clk,
    input  wire logic   arstN,
    input  wire logic   wbValid,
    input  wbT          wb1,
    input  wbT          wb2,
    input  regIdxT [3:0] raddr, // lane1 rs1, lane1 rs2, lane2 rs1, lane2 rs2
    output xlenT   [3:0] rdata
);

    xlenT regs [32];
    logic we1;
    logic we2;

    // lane 2 wins a collision on the same rd
    assign we2 = wbValid && wb2.regWrite && (wb2.rd != '0);
    assign we1 = wbValid && wb1.regWrite && (wb1.rd != '0)
                 && !(wb2.regWrite && (wb2.rd == wb1.rd));

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (we1) regs[wb1.rd] <= wb1.result;
            if (we2) regs[wb2.rd] <= wb2.result;
        end
    end

    // read ports see this cycle's writeback
    always_comb begin
        for (int p = 0; p < 4; p++) begin
            if (raddr[p] == '0) begin
                rdata[p] = '0; // x0
            end else if (we2 && (wb2.rd == raddr[p])) begin
                rdata[p] = wb2.result;
            end else if (we1 && (wb1.rd == raddr[p])) begin
                rdata[p] = wb1.result;
            end else begin
                rdata[p] = regs[raddr[p]];
            end
        end
    end

endmodule

`default_nettype wire

// File: design/decodeStage.sv
`timescale 1ns/1ps
`default_nettype none

module decodeStage
    import rvDecodePkg::*;
(
    input  wire logic  clk,
    input  wire logic  arstN,
    input  wire logic  inValid,
    output logic       inReady,
    input  ctrlT       ctrl1,
    input  ctrlT       ctrl2,
    input  xlenT [3:0] rdata,
    output logic       outValid,
    input  wire logic  outReady,
    output laneT       out1,
    output laneT       out2
);

    logic accept;

    // slot can take a pair when empty or draining this cycle
    assign inReady = !outValid || outReady;
    assign accept  = inValid && inReady;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            outValid <= 1'b0;
        end else if (accept) begin
            outValid <= 1'b1; // refill, also on a same-cycle transfer
        end else if (outReady) begin
            outValid <= 1'b0;
        end
    end

    // operands are captured with the pair, later writebacks do not touch them
    always_ff @(posedge clk) begin
        if (accept) begin
            out1.ctrl <= ctrl1;
            out1.rd1  <= rdata[0];
            out1.rd2  <= rdata[1];
            out2.ctrl <= ctrl2;
            out2.rd1  <= rdata[2];
            out2.rd2  <= rdata[3];
        end
    end

endmodule

`default_nettype wire

// File: design/dualDecodeTop.sv
`timescale 1ns/1ps
`default_nettype none

module dualDecodeTop
    import rvDecodePkg::*;
(
    input  wire logic clk,
    input  wire logic arstN,
    // instruction pair
    input  wire logic inValid,
    output logic      inReady,
    input  instrT     instr1,
    input  instrT     instr2,
    // decoded pair
    output logic      outValid,
    input  wire logic outReady,
    output laneT      out1,
    output laneT      out2,
    // writeback, no back-pressure
    input  wire logic wbValid,
    input  wbT        wb1,
    input  wbT        wb2
);

    ctrlT       ctrl1;
    ctrlT       ctrl2;
    xlenT [3:0] rdata;

    instrDecoder u_dec1 (
        .instr (instr1),
        .ctrl  (ctrl1)
    );

    instrDecoder u_dec2 (
        .instr (instr2),
        .ctrl  (ctrl2)
    );

    regFile u_regs (
        .clk     (clk),
        .arstN   (arstN),
        .wbValid (wbValid),
        .wb1     (wb1),
        .wb2     (wb2),
        .raddr   ({ctrl2.rs2, ctrl2.rs1, ctrl1.rs2, ctrl1.rs1}), // port 0 is lane 1 rs1
        .rdata   (rdata)
    );

    decodeStage u_stage (
        .clk      (clk),
        .arstN    (arstN),
        .inValid  (inValid),
        .inReady  (inReady),
        .ctrl1    (ctrl1),
        .ctrl2    (ctrl2),
        .rdata    (rdata),
        .outValid (outValid),
        .outReady (outReady),
        .out1     (out1),
        .out2     (out2)
    );

endmodule

`default_nettype wire

// File: test/clockGen.sv
`timescale 1ns/1ps
`default_nettype none

module clockGen #(
    parameter int HalfPeriod  = 20,
    parameter int ResetCycles = 16
) (
    output logic clk,
    output logic arstN
);

    initial begin
        clk = 1'b0;
        forever #(HalfPeriod) clk = ~clk; // 40 ns period
    end

    initial begin
        arstN = 1'b0;
        repeat (ResetCycles) @(posedge clk);
        #2 arstN = 1'b1; // release off the edge
    end

endmodule

`default_nettype wire

// File: include/tbRefModel.svh
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

xlenT shadowRegs [32]; // register contents as the testbench expects them

function automatic xlenT readShadow(regIdxT idx);
    return (idx == 5'd0) ? '0 : shadowRegs[idx]; // x0 reads zero
endfunction

// lane 1 first, so lane 2 overrides on the same rd
task automatic applyWb(logic valid, wbT w1, wbT w2);
    if (valid && w1.regWrite && w1.rd != 5'd0) shadowRegs[w1.rd] = w1.result;
    if (valid && w2.regWrite && w2.rd != 5'd0) shadowRegs[w2.rd] = w2.result;
endtask

function automatic ctrlT refDecode(instrT ins);
    ctrlT       c;
    logic [2:0] f3;
    logic [6:0] f7;
    c  = '0;
    f3 = ins[14:12];
    f7 = ins[31:25];
    case (ins[6:0])
        7'h03, 7'h13, 7'h1b, 7'h67: begin // I-type formats
            c.regWrite = 1'b1;
            c.aluSrc   = 1'b1;
            c.imm      = xlenT'($signed(ins[31:20]));
            c.rs1      = ins[19:15];
            c.rd       = ins[11:7];
        end
        7'h17, 7'h37: begin
            c.regWrite = 1'b1;
            c.aluSrc   = 1'b1;
            c.imm      = xlenT'($signed({ins[31:12], 12'h000}));
            c.rd       = ins[11:7];
            c.aluOp    = ins[5] ? aluLui : aluAuipc;
        end
        7'h23: begin
            c.mem      = '{memStore, f3};
            c.aluSrc   = 1'b1;
            c.imm      = xlenT'($signed({ins[31:25], ins[11:7]}));
            c.rs1      = ins[19:15];
            c.rs2      = ins[24:20];
            c.rd       = ins[11:7];
            c.aluOp    = aluAdd;
        end
        7'h33, 7'h3b: begin
            c.regWrite = 1'b1;
            c.rs1      = ins[19:15];
            c.rs2      = ins[24:20];
            c.rd       = ins[11:7];
        end
        7'h63: begin
            c.branch = 1'b1;
            c.imm    = xlenT'($signed({ins[31], ins[7], ins[30:25], ins[11:8], 1'b0}));
            c.rs1    = ins[19:15];
            c.rs2    = ins[24:20];
            case (f3)
                3'd0: c.aluOp = aluBeq;
                3'd1: c.aluOp = aluBne;
                3'd4: c.aluOp = aluBlt;
                3'd5: c.aluOp = aluBge;
                3'd6: c.aluOp = aluBltu;
                3'd7: c.aluOp = aluBgeu;
                default: c.aluOp = aluNop;
            endcase
        end
        7'h6f: begin
            c.regWrite = 1'b1;
            c.aluSrc   = 1'b1;
            c.imm      = xlenT'($signed({ins[31], ins[19:12], ins[20], ins[30:21], 1'b0}));
            c.rd       = ins[11:7];
        end
        default: c = '0;
    endcase
    case (ins[6:0])
        7'h03: begin
            c.resultSrc = resMem;
            c.mem       = '{memLoad, f3};
            c.aluOp     = aluAdd;
        end
        7'h13: begin
            case (f3)
                3'd0: c.aluOp = aluAdd;
                3'd1: c.aluOp = (ins[31:26] == 6'h00) ? aluSll : aluNop;
                3'd2: c.aluOp = aluSlt;
                3'd3: c.aluOp = aluSltu;
                3'd4: c.aluOp = aluXor;
                3'd5: c.aluOp = (ins[31:26] == 6'h00) ? aluSrl :
                                (ins[31:26] == 6'h10) ? aluSra : aluNop;
                3'd6: c.aluOp = aluOr;
                default: c.aluOp = aluAnd;
            endcase
        end
        7'h1b: begin
            if (f3 == 3'd0) c.aluOp = aluAddw;
            else if (f3 == 3'd1 && f7 == 7'h00) c.aluOp = aluSllw;
            else if (f3 == 3'd5 && f7 == 7'h00) c.aluOp = aluSrlw;
            else if (f3 == 3'd5 && f7 == 7'h20) c.aluOp = aluSraw;
        end
        7'h33: begin
            if (f7 == 7'h01) begin
                case (f3)
                    3'd0: c.aluOp = aluMul;
                    3'd1: c.aluOp = aluMulh;
                    3'd2: c.aluOp = aluMulhsu;
                    3'd3: c.aluOp = aluMulhu;
                    3'd4: c.aluOp = aluDiv;
                    3'd5: c.aluOp = aluDivu;
                    3'd6: c.aluOp = aluRem;
                    default: c.aluOp = aluRemu;
                endcase
            end else if (f7 == 7'h00) begin
                case (f3)
                    3'd0: c.aluOp = aluAdd;
                    3'd1: c.aluOp = aluSll;
                    3'd2: c.aluOp = aluSlt;
                    3'd3: c.aluOp = aluSltu;
                    3'd4: c.aluOp = aluXor;
                    3'd5: c.aluOp = aluSrl;
                    3'd6: c.aluOp = aluOr;
                    default: c.aluOp = aluAnd;
                endcase
            end else if (f7 == 7'h20 && f3 == 3'd0) c.aluOp = aluSub;
            else if (f7 == 7'h20 && f3 == 3'd5) c.aluOp = aluSra;
        end
        7'h3b: begin
            if (f7 == 7'h01) begin
                case (f3)
                    3'd0: c.aluOp = aluMulw;
                    3'd4: c.aluOp = aluDivw;
                    3'd5: c.aluOp = aluDivuw;
                    3'd6: c.aluOp = aluRemw;
                    3'd7: c.aluOp = aluRemuw;
                    default: c.aluOp = aluNop;
                endcase
            end else if (f7 == 7'h00 && f3 == 3'd0) c.aluOp = aluAddw;
            else if (f7 == 7'h00 && f3 == 3'd1) c.aluOp = aluSllw;
            else if (f7 == 7'h00 && f3 == 3'd5) c.aluOp = aluSrlw;
            else if (f7 == 7'h20 && f3 == 3'd0) c.aluOp = aluSubw;
            else if (f7 == 7'h20 && f3 == 3'd5) c.aluOp = aluSraw;
        end
        7'h67, 7'h6f: begin
            c.resultSrc = resPcPlus4;
            c.jump      = 1'b1;
            c.aluOp     = ins[3] ? aluJal : aluJalr;
        end
        default: ;
    endcase
    return c;
endfunction

`endif

// File: test/tbDualDecode.sv
`timescale 1ns/1ps
`default_nettype none

module tbDualDecode
    import rvDecodePkg::*;
;

    localparam int NumCycles = 600;
    localparam int Timeout   = 200;

    logic  clk;
    logic  arstN;
    logic  inValid;
    logic  inReady;
    instrT instr1;
    instrT instr2;
    logic  outValid;
    logic  outReady;
    laneT  out1;
    laneT  out2;
    logic  wbValid;
    wbT    wb1;
    wbT    wb2;

    laneT  expQ1 [$]; // one entry per pair in flight
    laneT  expQ2 [$];
    laneT  expLane1;
    laneT  expLane2;
    int    waitCnt;

    `include "tbRefModel.svh"

    clockGen #(.HalfPeriod(20), .ResetCycles(16)) u_clk (.clk(clk), .arstN(arstN));

    dualDecodeTop u_dut (
        .clk(clk), .arstN(arstN),
        .inValid(inValid), .inReady(inReady), .instr1(instr1), .instr2(instr2),
        .outValid(outValid), .outReady(outReady), .out1(out1), .out2(out2),
        .wbValid(wbValid), .wb1(wb1), .wb2(wb2)
    );

    task automatic stopFail();
        $display("Result: FAILED");
        $fatal(1, "testbench stopped");
    endtask

    task automatic checkCtrl(string name, ctrlT exp, ctrlT act);
        if (exp !== act) begin
            $display("Fail t=%0t %s exp=%h act=%h", $time, name, exp, act);
            stopFail();
        end
    endtask

    task automatic checkData(string name, xlenT exp, xlenT act);
        if (exp !== act) begin
            $display("Fail t=%0t %s exp=%h act=%h", $time, name, exp, act);
            stopFail();
        end
    endtask

    task automatic checkFlag(string name, bit exp, logic act);
        if (exp !== act) begin
            $display("Fail t=%0t %s exp=%b act=%b", $time, name, exp, act);
            stopFail();
        end
    endtask

    // small register range so reads hit recent writes
    function automatic instrT randInstr();
        instrT w;
        w        = $urandom;
        w[19:15] = 5'($urandom_range(0, 7));
        w[24:20] = 5'($urandom_range(0, 7));
        w[11:7]  = 5'($urandom_range(0, 7));
        case ($urandom_range(0, 12))
            0: w[6:0] = 7'h03;
            1: w[6:0] = 7'h13;
            2: w[6:0] = 7'h17;
            3: w[6:0] = 7'h1b;
            4: w[6:0] = 7'h23;
            5: w[6:0] = 7'h33;
            6: w[6:0] = 7'h37;
            7: w[6:0] = 7'h3b;
            8: w[6:0] = 7'h63;
            9: w[6:0] = 7'h67;
            10: w[6:0] = 7'h6f;
            default: ; // raw random word
        endcase
        case ($urandom_range(0, 3))
            0: w[31:25] = 7'h00;
            1: w[31:25] = 7'h01;
            2: w[31:25] = 7'h20;
            default: ;
        endcase
        return w;
    endfunction

    function automatic wbT randWb(regIdxT rd);
        wbT w;
        w.regWrite = 1'($urandom_range(0, 3) != 0);
        w.rd       = rd;
        w.result   = {32'($urandom), 32'($urandom)};
        return w;
    endfunction

    // mid-cycle scoreboard, all DUT signals are settled here
    always @(negedge clk) begin
        if (arstN) begin
            checkFlag("inReady", expQ1.size() == 0 || outReady, inReady);
            checkFlag("outValid", expQ1.size() != 0, outValid);
            if (expQ1.size() != 0) begin
                checkCtrl("out1.ctrl", expQ1[0].ctrl, out1.ctrl);
                checkData("out1.rd1", expQ1[0].rd1, out1.rd1);
                checkData("out1.rd2", expQ1[0].rd2, out1.rd2);
                checkCtrl("out2.ctrl", expQ2[0].ctrl, out2.ctrl);
                checkData("out2.rd1", expQ2[0].rd1, out2.rd1);
                checkData("out2.rd2", expQ2[0].rd2, out2.rd2);
                if (outReady) begin
                    void'(expQ1.pop_front());
                    void'(expQ2.pop_front());
                end
            end
            applyWb(wbValid, wb1, wb2); // commits on the coming edge, bypassed to reads
            if (inValid && (expQ1.size() == 0 || outReady)) begin
                expLane1.ctrl = refDecode(instr1);
                expLane1.rd1  = readShadow(expLane1.ctrl.rs1);
                expLane1.rd2  = readShadow(expLane1.ctrl.rs2);
                expLane2.ctrl = refDecode(instr2);
                expLane2.rd1  = readShadow(expLane2.ctrl.rs1);
                expLane2.rd2  = readShadow(expLane2.ctrl.rs2);
                expQ1.push_back(expLane1);
                expQ2.push_back(expLane2);
            end
        end
    end

    initial begin
        void'($urandom(32'h2a69_b253));
        inValid  = 1'b0;
        instr1   = '0;
        instr2   = '0;
        outReady = 1'b1;
        wbValid  = 1'b0;
        wb1      = '0;
        wb2      = '0;
        for (int i = 0; i < 32; i++) shadowRegs[i] = '0;
        waitCnt = 0;
        while (arstN !== 1'b1) begin
            @(posedge clk);
            waitCnt++;
            if (waitCnt > Timeout) begin
                $display("reset was never released");
                stopFail();
            end
        end
        for (int i = 0; i < NumCycles; i++) begin
            @(posedge clk);
            #2;
            inValid = ($urandom_range(0, 3) != 0);
            instr1  = randInstr();
            instr2  = randInstr();
            if (i < 150) outReady = 1'b1;
            else if (i < 350) outReady = 1'($urandom_range(0, 1));
            else outReady = 1'(((i / 20) % 2) == 1); // long stalls
            wbValid = 1'($urandom_range(0, 1));
            wb1     = randWb(5'($urandom_range(0, 7)));
            wb2     = randWb(($urandom_range(0, 3) == 0) ? wb1.rd : 5'($urandom_range(0, 7)));
        end
        @(posedge clk);
        #2;
        inValid  = 1'b0;
        wbValid  = 1'b0;
        outReady = 1'b1;
        waitCnt  = 0;
        while (expQ1.size() != 0) begin
            @(posedge clk);
            waitCnt++;
            if (waitCnt > Timeout) begin
                $display("output slot did not drain");
                stopFail();
            end
        end
        @(negedge clk);
        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
+incdir+include
design/rvDecodePkg.sv
design/instrDecoder.sv
design/regFile.sv
design/decodeStage.sv
design/dualDecodeTop.sv
test/clockGen.sv
test/tbDualDecode.sv

// File: run.sh
#!/bin/sh
# build with Verilator and run, pass only if the log holds the pass line
rm -f sim.log
verilator --binary --timing --top-module tbDualDecode -f flist.f -o simv \
    && ./obj_dir/simv > sim.log 2>&1
grep -q "Result: PASSED" sim.log && echo "simulation passed" || {
    echo "simulation failed"
    exit 1
}
